// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tbCore
FILELIST  ?= src.f
OBJDIR    ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== logic/cpuCore.sv ====
`timescale 1ns/10ps

module cpuCore (
    input  logic                        clk_i,
    input  logic                        rst_i,
    output logic [cpuPkg::XLen-1:0]     imem_addr_o,
    input  logic [cpuPkg::XLen-1:0]     imem_data_i,
    output logic                        dmem_req_o,
    output logic                        dmem_we_o,
    output logic [cpuPkg::XLen-1:0]     dmem_addr_o,
    output logic [cpuPkg::XLen-1:0]     dmem_wdata_o,
    input  logic                        dmem_rsp_i,
    input  logic [cpuPkg::XLen-1:0]     dmem_rdata_i,
    output logic                        wb_we_o,
    output logic [cpuPkg::XLen-1:0]     wb_pc_o,
    output logic [cpuPkg::RegAddrW-1:0] wb_reg_o,
    output logic [cpuPkg::XLen-1:0]     wb_data_o
);

    pipeCtrlIf ctrlIf ();

    cpuPkg::decoded_t        decD, decE, decM;
    logic [cpuPkg::XLen-1:0] fetchPc;
    logic [cpuPkg::XLen-1:0] pcE, opAE, opBE, immE, resultE;
    logic [cpuPkg::XLen-1:0] resultM, storeDataM, pcM;
    logic                    takenE, memBusy, loadPendingM;

    fetchUnit fetch_i (
        .clk_i, .rst_i, .ctrl(ctrlIf.fetch), .pc_o(imem_addr_o), .fetchPc_o(fetchPc)
    );

    decodeUnit decode_i (
        .clk_i, .rst_i, .ctrl(ctrlIf.decode), .instr_i(imem_data_i), .pc_i(fetchPc),
        .wbWe_i(wb_we_o), .wbReg_i(wb_reg_o), .wbData_i(wb_data_o),
        .fwdEValid_i(decE.regWrite), .fwdEReg_i(decE.writeReg), .fwdEData_i(resultE),
        .fwdMValid_i(wb_we_o), .fwdMReg_i(wb_reg_o), .fwdMData_i(wb_data_o),
        .dec_o(decD), .decE_o(decE), .pcE_o(pcE), .opAE_o(opAE), .opBE_o(opBE),
        .immE_o(immE)
    );

    executeUnit execute_i (
        .clk_i, .rst_i, .ctrl(ctrlIf.exec), .decE_i(decE), .pcE_i(pcE), .opAE_i(opAE),
        .opBE_i(opBE), .immE_i(immE), .resultE_o(resultE), .takenE_o(takenE),
        .decM_o(decM), .resultM_o(resultM), .storeDataM_o(storeDataM), .pcM_o(pcM)
    );

    memAccess mem_i (
        .clk_i, .rst_i, .decM_i(decM), .resultM_i(resultM), .storeDataM_i(storeDataM),
        .pcM_i(pcM), .dmem_req_o, .dmem_we_o, .dmem_addr_o, .dmem_wdata_o, .dmem_rsp_i,
        .dmem_rdata_i, .memBusy_o(memBusy), .loadPendingM_o(loadPendingM),
        .wbWe_o(wb_we_o), .wbReg_o(wb_reg_o), .wbData_o(wb_data_o), .wbPc_o(wb_pc_o)
    );

    pipeControl control_i (
        .ctrl(ctrlIf.ctrl), .decD_i(decD), .decE_i(decE), .decM_i(decM),
        .takenE_i(takenE), .memBusy_i(memBusy), .loadPendingM_i(loadPendingM)
    );

endmodule

// ==== logic/cpuPkg.sv ====
package cpuPkg;

    localparam int XLen     = 32;
    localparam int RegAddrW = 5;

    localparam logic [XLen-1:0] ResetPc = '0;
    localparam logic [XLen-1:0] NopWord = '0;  // sll $0,$0,0 decodes to nothing

    // data memory flow control
    localparam int MemCredits = 2;
    localparam int CreditW    = $clog2(MemCredits + 1);

    typedef enum logic [5:0] {
        OpSpecial = 6'h00,
        OpBeq     = 6'h04,
        OpBne     = 6'h05,
        OpAddiu   = 6'h09,
        OpOri     = 6'h0d,
        OpLui     = 6'h0f,
        OpLw      = 6'h23,
        OpSw      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FnAddu = 6'h21,
        FnSubu = 6'h23,
        FnAnd  = 6'h24,
        FnOr   = 6'h25,
        FnXor  = 6'h26,
        FnSlt  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluSlt,
        AluLui
    } aluOp_e;

    typedef struct packed {
        aluOp_e              aluOp;
        logic                useImm;
        logic                regWrite;       // never set for $0
        logic [RegAddrW-1:0] writeReg;
        logic                isLoad;
        logic                isStore;
        logic                isBranch;
        logic                branchOnEqual;
        logic [RegAddrW-1:0] rs;             // zero when not read
        logic [RegAddrW-1:0] rt;
    } decoded_t;

    // pipeline bubble
    localparam decoded_t NopDec = '{aluOp: AluAdd, default: '0};

endpackage

// ==== logic/decodeUnit.sv ====
`timescale 1ns/10ps

module decodeUnit (
    input  logic                        clk_i,
    input  logic                        rst_i,
    pipeCtrlIf.decode                   ctrl,
    input  logic [cpuPkg::XLen-1:0]     instr_i,
    input  logic [cpuPkg::XLen-1:0]     pc_i,
    input  logic                        wbWe_i,
    input  logic [cpuPkg::RegAddrW-1:0] wbReg_i,
    input  logic [cpuPkg::XLen-1:0]     wbData_i,
    input  logic                        fwdEValid_i,
    input  logic [cpuPkg::RegAddrW-1:0] fwdEReg_i,
    input  logic [cpuPkg::XLen-1:0]     fwdEData_i,
    input  logic                        fwdMValid_i,
    input  logic [cpuPkg::RegAddrW-1:0] fwdMReg_i,
    input  logic [cpuPkg::XLen-1:0]     fwdMData_i,
    output cpuPkg::decoded_t            dec_o,
    output cpuPkg::decoded_t            decE_o,
    output logic [cpuPkg::XLen-1:0]     pcE_o,
    output logic [cpuPkg::XLen-1:0]     opAE_o,
    output logic [cpuPkg::XLen-1:0]     opBE_o,
    output logic [cpuPkg::XLen-1:0]     immE_o
);

    logic [cpuPkg::XLen-1:0] regFile [2**cpuPkg::RegAddrW];
    logic                    wordValid;  // word from fetch still belongs to the program
    logic [cpuPkg::XLen-1:0] word;
    logic                    zeroExt;
    logic [cpuPkg::XLen-1:0] imm;
    cpuPkg::decoded_t        dec;

    // execute result is younger than memory result
    function automatic logic [cpuPkg::XLen-1:0] readOperand(
        input logic [cpuPkg::RegAddrW-1:0] r
    );
        logic [cpuPkg::XLen-1:0] value;
        if (r == '0) begin
            value = '0;
        end else if (fwdEValid_i && fwdEReg_i == r) begin
            value = fwdEData_i;
        end else if (fwdMValid_i && fwdMReg_i == r) begin
            value = fwdMData_i;
        end else begin
            value = regFile[r];
        end
        return value;
    endfunction

    assign word = wordValid ? instr_i : cpuPkg::NopWord;
    assign imm  = zeroExt ? {16'b0, word[15:0]} : {{16{word[15]}}, word[15:0]};

    always_comb begin
        dec          = cpuPkg::NopDec;
        dec.writeReg = word[20:16];  // rt for all immediate forms
        zeroExt      = 1'b0;
        case (cpuPkg::opcode_e'(word[31:26]))
            cpuPkg::OpSpecial: begin
                dec.rs       = word[25:21];
                dec.rt       = word[20:16];
                dec.writeReg = word[15:11];
                dec.regWrite = 1'b1;
                case (cpuPkg::funct_e'(word[5:0]))
                    cpuPkg::FnAddu: dec.aluOp = cpuPkg::AluAdd;
                    cpuPkg::FnSubu: dec.aluOp = cpuPkg::AluSub;
                    cpuPkg::FnAnd:  dec.aluOp = cpuPkg::AluAnd;
                    cpuPkg::FnOr:   dec.aluOp = cpuPkg::AluOr;
                    cpuPkg::FnXor:  dec.aluOp = cpuPkg::AluXor;
                    cpuPkg::FnSlt:  dec.aluOp = cpuPkg::AluSlt;
                    default:        dec = cpuPkg::NopDec;
                endcase
            end
            cpuPkg::OpAddiu, cpuPkg::OpOri, cpuPkg::OpLui, cpuPkg::OpLw: begin
                dec.rs       = (word[31:26] == cpuPkg::OpLui) ? '0 : word[25:21];
                dec.useImm   = 1'b1;
                dec.regWrite = 1'b1;
                dec.isLoad   = (word[31:26] == cpuPkg::OpLw);
                if (word[31:26] == cpuPkg::OpOri) begin
                    dec.aluOp = cpuPkg::AluOr;
                    zeroExt   = 1'b1;
                end else if (word[31:26] == cpuPkg::OpLui) begin
                    dec.aluOp = cpuPkg::AluLui;
                end
            end
            cpuPkg::OpSw: begin
                dec.rs      = word[25:21];
                dec.rt      = word[20:16];  // store data
                dec.useImm  = 1'b1;
                dec.isStore = 1'b1;
            end
            cpuPkg::OpBeq, cpuPkg::OpBne: begin
                dec.rs            = word[25:21];
                dec.rt            = word[20:16];
                dec.isBranch      = 1'b1;
                dec.branchOnEqual = (word[31:26] == cpuPkg::OpBeq);
            end
            default: dec = cpuPkg::NopDec;  // anything else does nothing
        endcase
        if (dec.writeReg == '0) begin
            dec.regWrite = 1'b0;
        end
    end

    assign dec_o = dec;

    always_ff @(posedge clk_i) begin
        if (wbWe_i) begin
            regFile[wbReg_i] <= wbData_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wordValid <= 1'b0;
            decE_o    <= cpuPkg::NopDec;
        end else begin
            if (!ctrl.stallD) begin
                wordValid <= !ctrl.flushD;  // drop the word fetched behind a taken branch
            end
            if (ctrl.flushD) begin
                decE_o <= cpuPkg::NopDec;
            end else if (!ctrl.stallD) begin
                decE_o <= dec;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!ctrl.stallD) begin
            pcE_o  <= pc_i;
            opAE_o <= readOperand(dec.rs);
            opBE_o <= readOperand(dec.rt);
            immE_o <= imm;
        end
    end

    // $0 targets are dropped in decode, so writeback never reaches register 0
    zeroRegKept: assert property (@(posedge clk_i) disable iff (rst_i)
        wbWe_i |-> wbReg_i != '0);

endmodule

// ==== logic/executeUnit.sv ====
`timescale 1ns/10ps

module executeUnit (
    input  logic                    clk_i,
    input  logic                    rst_i,
    pipeCtrlIf.exec                 ctrl,
    input  cpuPkg::decoded_t        decE_i,
    input  logic [cpuPkg::XLen-1:0] pcE_i,
    input  logic [cpuPkg::XLen-1:0] opAE_i,
    input  logic [cpuPkg::XLen-1:0] opBE_i,
    input  logic [cpuPkg::XLen-1:0] immE_i,
    output logic [cpuPkg::XLen-1:0] resultE_o,
    output logic                    takenE_o,
    output cpuPkg::decoded_t        decM_o,
    output logic [cpuPkg::XLen-1:0] resultM_o,
    output logic [cpuPkg::XLen-1:0] storeDataM_o,
    output logic [cpuPkg::XLen-1:0] pcM_o
);

    logic [cpuPkg::XLen-1:0] srcB;
    logic                    operandsEqual;

    assign srcB = decE_i.useImm ? immE_i : opBE_i;

    always_comb begin
        case (decE_i.aluOp)
            cpuPkg::AluSub: resultE_o = opAE_i - srcB;
            cpuPkg::AluAnd: resultE_o = opAE_i & srcB;
            cpuPkg::AluOr:  resultE_o = opAE_i | srcB;
            cpuPkg::AluXor: resultE_o = opAE_i ^ srcB;
            cpuPkg::AluSlt: resultE_o = {31'b0, $signed(opAE_i) < $signed(srcB)};
            cpuPkg::AluLui: resultE_o = {srcB[15:0], 16'b0};
            default:        resultE_o = opAE_i + srcB;  // add, also load/store address
        endcase
    end

    // beq/bne resolve here, no delay slot
    assign operandsEqual   = (opAE_i == opBE_i);
    assign takenE_o        = decE_i.isBranch && !ctrl.stallE
                             && (operandsEqual == decE_i.branchOnEqual);
    assign ctrl.redirectPc = pcE_i + cpuPkg::XLen'(4) + {immE_i[29:0], 2'b00};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            decM_o <= cpuPkg::NopDec;
        end else if (!ctrl.stallE) begin
            decM_o <= ctrl.flushE ? cpuPkg::NopDec : decE_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!ctrl.stallE) begin
            resultM_o    <= resultE_o;
            storeDataM_o <= opBE_i;
            pcM_o        <= pcE_i;
        end
    end

endmodule

// ==== logic/fetchUnit.sv ====
`timescale 1ns/10ps

module fetchUnit (
    input  logic                    clk_i,
    input  logic                    rst_i,
    pipeCtrlIf.fetch                ctrl,
    output logic [cpuPkg::XLen-1:0] pc_o,
    output logic [cpuPkg::XLen-1:0] fetchPc_o
);

    logic [cpuPkg::XLen-1:0] pcReg;    // next address to request
    logic [cpuPkg::XLen-1:0] fetchPc;  // address requested last cycle

    // while decode is held the same word is read again
    assign pc_o      = ctrl.stallF ? fetchPc : pcReg;
    assign fetchPc_o = fetchPc;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pcReg   <= cpuPkg::ResetPc;
            fetchPc <= cpuPkg::ResetPc;
        end else begin
            fetchPc <= pc_o;
            if (ctrl.redirect) begin
                pcReg <= ctrl.redirectPc;  // taken branch wins
            end else if (!ctrl.stallF) begin
                pcReg <= pcReg + cpuPkg::XLen'(4);
            end
        end
    end

endmodule

// ==== logic/memAccess.sv ====
`timescale 1ns/10ps

module memAccess (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  cpuPkg::decoded_t            decM_i,
    input  logic [cpuPkg::XLen-1:0]     resultM_i,
    input  logic [cpuPkg::XLen-1:0]     storeDataM_i,
    input  logic [cpuPkg::XLen-1:0]     pcM_i,
    output logic                        dmem_req_o,
    output logic                        dmem_we_o,
    output logic [cpuPkg::XLen-1:0]     dmem_addr_o,
    output logic [cpuPkg::XLen-1:0]     dmem_wdata_o,
    input  logic                        dmem_rsp_i,
    input  logic [cpuPkg::XLen-1:0]     dmem_rdata_i,
    output logic                        memBusy_o,
    output logic                        loadPendingM_o,
    output logic                        wbWe_o,
    output logic [cpuPkg::RegAddrW-1:0] wbReg_o,
    output logic [cpuPkg::XLen-1:0]     wbData_o,
    output logic [cpuPkg::XLen-1:0]     wbPc_o
);

    logic [cpuPkg::CreditW-1:0] credits;
    logic                       loadIssued;  // load sent, waiting for its data
    logic                       loadDone;

    assign dmem_req_o   = (decM_i.isLoad || decM_i.isStore) && !loadIssued && credits != '0;
    assign dmem_we_o    = decM_i.isStore;
    assign dmem_addr_o  = resultM_i;
    assign dmem_wdata_o = storeDataM_i;

    // nothing issues behind a waiting load, so its response is the last one outstanding
    assign loadDone = decM_i.isLoad && loadIssued && dmem_rsp_i
                      && credits == cpuPkg::CreditW'(cpuPkg::MemCredits - 1);

    assign loadPendingM_o = decM_i.isLoad && !loadDone;
    assign memBusy_o      = decM_i.isLoad ? !loadDone : (decM_i.isStore && credits == '0);

    assign wbWe_o   = decM_i.regWrite && (!decM_i.isLoad || loadDone);
    assign wbReg_o  = decM_i.writeReg;
    assign wbData_o = decM_i.isLoad ? dmem_rdata_i : resultM_i;
    assign wbPc_o   = pcM_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            credits    <= cpuPkg::CreditW'(cpuPkg::MemCredits);
            loadIssued <= 1'b0;
        end else begin
            case ({dmem_req_o, dmem_rsp_i})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;  // none, or one out and one back
            endcase
            if (loadDone) begin
                loadIssued <= 1'b0;
            end else if (dmem_req_o && decM_i.isLoad) begin
                loadIssued <= 1'b1;
            end
        end
    end

    creditBound: assert property (@(posedge clk_i) disable iff (rst_i)
        credits <= cpuPkg::CreditW'(cpuPkg::MemCredits));
    // a response with nothing outstanding is a protocol error from memory
    rspOutstanding: assert property (@(posedge clk_i) disable iff (rst_i)
        dmem_rsp_i |-> credits != cpuPkg::CreditW'(cpuPkg::MemCredits));

endmodule

// ==== logic/pipeControl.sv ====
`timescale 1ns/10ps

module pipeControl (
    pipeCtrlIf.ctrl          ctrl,
    input cpuPkg::decoded_t  decD_i,
    input cpuPkg::decoded_t  decE_i,
    input cpuPkg::decoded_t  decM_i,
    input logic              takenE_i,
    input logic              memBusy_i,
    input logic              loadPendingM_i
);

    logic hitE;
    logic hitM;
    logic loadUse;

    // decode reads a register that a load will write
    function automatic logic readsReg(
        input cpuPkg::decoded_t              d,
        input logic [cpuPkg::RegAddrW-1:0]   r
    );
        return r != '0 && (d.rs == r || d.rt == r);
    endfunction

    assign hitE    = decE_i.isLoad && decE_i.regWrite && readsReg(decD_i, decE_i.writeReg);
    assign hitM    = loadPendingM_i && decM_i.regWrite && readsReg(decD_i, decM_i.writeReg);
    assign loadUse = hitE || hitM;

    // memory back-pressure freezes everything
    assign ctrl.stallE = memBusy_i;
    assign ctrl.stallD = memBusy_i || loadUse;
    assign ctrl.stallF = memBusy_i || loadUse;

    // bubble into execute, but never over a frozen execute stage
    assign ctrl.flushD   = takenE_i || (loadUse && !memBusy_i);
    assign ctrl.flushE   = takenE_i;  // the branch itself leaves as a bubble
    assign ctrl.redirect = takenE_i;

endmodule

// ==== logic/pipeCtrlIf.sv ====
`timescale 1ns/10ps

interface pipeCtrlIf;

    logic                    stallF;
    logic                    stallD;  // word in decode is kept
    logic                    stallE;
    logic                    flushD;  // bubble into execute
    logic                    flushE;
    logic                    redirect;
    logic [cpuPkg::XLen-1:0] redirectPc;

    modport ctrl (
        output stallF, stallD, stallE, flushD, flushE, redirect
    );
    modport exec (output redirectPc, input stallE, flushE);
    modport fetch (input stallF, redirect, redirectPc);
    modport decode (input stallD, flushD);

endinterface

// ==== src.f ====
+incdir+verification
logic/cpuPkg.sv
logic/pipeCtrlIf.sv
logic/fetchUnit.sv
logic/decodeUnit.sv
logic/executeUnit.sv
logic/memAccess.sv
logic/pipeControl.sv
logic/cpuCore.sv
verification/tbCore.sv

// ==== verification/coreModel.svh ====
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

localparam int ProgLen   = 200;
localparam int ImemWords = 256;
localparam int DmemWords = 64;  // 256 bytes of data

logic [31:0] progMem [ImemWords];
logic [31:0] modelMem [DmemWords];
logic [31:0] modelReg [32];

// expected writeback stream, oldest first
logic [31:0] expPc [$];
logic [4:0]  expReg [$];
logic [31:0] expData [$];
int          expReqs;  // loads plus stores on the executed path

// responder queue, one entry per outstanding request
int          rspDue [$];
logic [31:0] rspData [$];

function automatic logic [31:0] encodeR(
    input logic [5:0] funct,
    input logic [2:0] rd,
    input logic [2:0] rs,
    input logic [2:0] rt
);
    return {6'h00, 2'b00, rs, 2'b00, rt, 2'b00, rd, 5'h00, funct};
endfunction

function automatic logic [31:0] encodeI(
    input logic [5:0]  op,
    input logic [2:0]  rs,
    input logic [2:0]  rt,
    input logic [15:0] imm
);
    return {op, 2'b00, rs, 2'b00, rt, imm};
endfunction

// both halves follow the byte address
function automatic logic [31:0] fillWord(input int idx);
    logic [15:0] addr;
    addr = 16'(idx * 4);
    return {~addr, addr ^ 16'h5a5a};
endfunction

task automatic buildProgram();
    logic [5:0]  functs [6];
    logic [2:0]  rs;
    logic [2:0]  rt;
    logic [15:0] imm;
    int          kind;
    functs = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2a};
    for (int i = 0; i < ImemWords; i++) begin
        progMem[i] = '0;  // zero words after the program
    end
    for (int i = 0; i < ProgLen; i++) begin
        rs   = 3'($urandom_range(7, 0));
        rt   = 3'($urandom_range(7, 0));
        imm  = 16'($urandom());
        kind = int'($urandom_range(11, 0));
        if (i < 7) begin
            progMem[i] = encodeI(6'h09, 3'd0, 3'(i + 1), imm);  // give r1..r7 a value
        end else if (kind < 6) begin
            progMem[i] = encodeR(functs[kind], 3'($urandom_range(7, 0)), rs, rt);
        end else begin
            case (kind)
                6:  progMem[i] = encodeI(6'h09, rs, rt, imm);
                7:  progMem[i] = encodeI(6'h0d, rs, rt, imm);
                8:  progMem[i] = encodeI(6'h0f, 3'd0, rt, imm);
                9:  progMem[i] = encodeI(6'h23, 3'd0, rt, 16'($urandom_range(63, 0) * 4));
                10: progMem[i] = encodeI(6'h2b, 3'd0, rt, 16'($urandom_range(63, 0) * 4));
                default: begin
                    if ($urandom_range(1, 0) == 1) begin
                        rt = rs;  // forces beq taken, bne not taken
                    end
                    progMem[i] = encodeI($urandom_range(1, 0) == 1 ? 6'h04 : 6'h05, rs, rt,
                                         16'($urandom_range(3, 1)));
                end
            endcase
        end
    end
endtask

// architectural run in program order, no pipeline
task automatic runModel();
    int          pc;
    int          next;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] simm;
    logic [31:0] addr;
    logic [31:0] value;
    logic [4:0]  dst;
    logic        writes;
    for (int r = 0; r < 32; r++) begin
        modelReg[r] = '0;
    end
    for (int i = 0; i < DmemWords; i++) begin
        modelMem[i] = fillWord(i);
    end
    expReqs = 0;
    pc      = 0;
    while (pc < ProgLen) begin
        w      = progMem[pc];
        a      = modelReg[w[25:21]];
        b      = modelReg[w[20:16]];
        simm   = {{16{w[15]}}, w[15:0]};
        addr   = a + simm;
        next   = pc + 1;
        writes = 1'b1;
        dst    = w[20:16];
        value  = '0;
        case (w[31:26])
            6'h00: begin
                dst = w[15:11];
                case (w[5:0])
                    6'h21:   value = a + b;
                    6'h23:   value = a - b;
                    6'h24:   value = a & b;
                    6'h25:   value = a | b;
                    6'h26:   value = a ^ b;
                    6'h2a:   value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: writes = 1'b0;
                endcase
            end
            6'h09: value = addr;
            6'h0d: value = a | {16'h0000, w[15:0]};
            6'h0f: value = {w[15:0], 16'h0000};
            6'h23: begin
                value = modelMem[addr[7:2]];
                expReqs++;
            end
            6'h2b: begin
                writes              = 1'b0;
                modelMem[addr[7:2]] = b;
                expReqs++;
            end
            6'h04, 6'h05: begin
                writes = 1'b0;
                if ((a == b) == (w[31:26] == 6'h04)) begin
                    next = pc + 1 + int'($signed(simm));
                end
            end
            default: writes = 1'b0;  // anything else is a no-op
        endcase
        if (writes && dst != 5'd0) begin
            modelReg[dst] = value;
            expPc.push_back(32'(pc * 4));
            expReg.push_back(dst);
            expData.push_back(value);
        end
        pc = next;
    end
endtask

`endif

// ==== verification/tbCore.sv ====
`timescale 1ns/10ps

module tbCore;

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] imemAddr;
    logic [31:0] imemData;
    logic        dmemReq;
    logic        dmemWe;
    logic [31:0] dmemAddr;
    logic [31:0] dmemWdata;
    logic        dmemRsp;
    logic [31:0] dmemRdata;
    logic        wbWe;
    logic [31:0] wbPc;
    logic [4:0]  wbReg;
    logic [31:0] wbData;
    int          cycle;
    int          reqCount;  // requests accepted
    int          rspCount;  // responses seen by the core

    `include "coreModel.svh"

    logic [31:0] dataMem [DmemWords];

    cpuCore dut_i (
        .clk_i(clk), .rst_i(rst), .imem_addr_o(imemAddr), .imem_data_i(imemData),
        .dmem_req_o(dmemReq), .dmem_we_o(dmemWe), .dmem_addr_o(dmemAddr),
        .dmem_wdata_o(dmemWdata), .dmem_rsp_i(dmemRsp), .dmem_rdata_i(dmemRdata),
        .wb_we_o(wbWe), .wb_pc_o(wbPc), .wb_reg_o(wbReg), .wb_data_o(wbData)
    );

    always #4 clk = ~clk;

    task automatic stopRun();
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    // imem answers one cycle late, dmem answers the oldest due request
    always @(posedge clk) begin
        cycle = cycle + 1;
        imemData <= (imemAddr < ImemWords * 4) ? progMem[imemAddr[9:2]] : '0;
        if (rspDue.size() > 0 && rspDue[0] <= cycle) begin
            dmemRsp   <= 1'b1;
            dmemRdata <= rspData.pop_front();
            void'(rspDue.pop_front());
        end else begin
            dmemRsp   <= 1'b0;
            dmemRdata <= '0;
        end
    end

    task automatic checkWriteback();
        assert (expPc.size() > 0) else begin
            $display("writeback from pc %h after the last expected write", wbPc);
            stopRun();
        end
        assert (wbReg != 5'd0) else begin
            $display("FAILED wb_reg_o got %h with wb_data_o %h", wbReg, wbData);
            stopRun();
        end
        assert (wbPc == expPc[0]) else begin
            $display("FAILED wb_pc_o got %h expected %h", wbPc, expPc[0]);
            stopRun();
        end
        assert (wbReg == expReg[0]) else begin
            $display("FAILED wb_reg_o got %h expected %h (pc %h)", wbReg, expReg[0], wbPc);
            stopRun();
        end
        assert (wbData == expData[0]) else begin
            $display("FAILED wb_data_o got %h expected %h (pc %h)", wbData, expData[0], wbPc);
            stopRun();
        end
        void'(expPc.pop_front());
        void'(expReg.pop_front());
        void'(expData.pop_front());
    endtask

    task automatic acceptRequest();
        int idx;
        assert (dmemAddr < DmemWords * 4 && dmemAddr[1:0] == 2'b00) else begin
            $display("data request to address %h outside the test window", dmemAddr);
            stopRun();
        end
        idx = int'(dmemAddr[7:2]);
        if (dmemWe) begin
            dataMem[idx] = dmemWdata;
        end
        rspDue.push_back(cycle + int'($urandom_range(5, 1)));
        rspData.push_back(dmemWe ? 32'h0 : dataMem[idx]);
        reqCount++;
        // the response in flight this cycle still holds its credit
        assert (rspDue.size() + int'(dmemRsp) <= cpuPkg::MemCredits) else begin
            $display("more data requests outstanding than the core has credits");
            stopRun();
        end
    endtask

    // outputs settle after the rising edge, so look at them mid cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (wbWe) begin
                checkWriteback();
            end
            if (dmemRsp) begin
                rspCount++;
            end
            if (dmemReq) begin
                acceptRequest();
            end
        end
    end

    task automatic waitForWrites();
        int idle;
        int total;
        int left;
        total = 0;
        while (expPc.size() > 0) begin
            left = expPc.size();
            idle = 0;
            while (expPc.size() == left) begin
                @(posedge clk);
                idle++;
                total++;
                assert (idle <= 200) else begin
                    $display("no writeback for 200 cycles, %0d writes still expected", left);
                    stopRun();
                end
                assert (total <= 20000) else begin
                    $display("program did not finish within 20000 cycles");
                    stopRun();
                end
            end
        end
    endtask

    // trailing stores can still be in flight after the last write
    task automatic waitForMemory();
        int waited;
        waited = 0;
        while (reqCount < expReqs || rspCount < reqCount) begin
            @(posedge clk);
            waited++;
            assert (waited <= 200) else begin
                $display("data memory traffic did not drain within 200 cycles");
                stopRun();
            end
        end
        assert (reqCount == expReqs) else begin
            $display("core issued %0d data requests, program has %0d", reqCount, expReqs);
            stopRun();
        end
    endtask

    task automatic checkMemory();
        for (int i = 0; i < DmemWords; i++) begin
            assert (dataMem[i] == modelMem[i]) else begin
                $display("FAILED dataMem[%0d] got %h expected %h", i, dataMem[i], modelMem[i]);
                stopRun();
            end
        end
    endtask

    initial begin
        rst       = 1'b1;
        imemData  = '0;
        dmemRsp   = 1'b0;
        dmemRdata = '0;
        cycle     = 0;
        reqCount  = 0;
        rspCount  = 0;
        void'($urandom(63));
        buildProgram();
        runModel();
        for (int i = 0; i < DmemWords; i++) begin
            dataMem[i] = fillWord(i);
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        waitForWrites();
        waitForMemory();
        checkMemory();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
